/* rtl/elevator_pkg.sv */
// Floor numbers are 4 bits wide, so one car serves at most 16 floors, numbered from 0
package elevator_pkg;

    //////////////////////////////////////////////////////////////////////
    // Sizes
    //////////////////////////////////////////////////////////////////////

    // Width of a floor number on every port
    localparam int FLOOR_W = 4;

    // Largest floor count that FLOOR_W can address
    localparam int MAX_FLOORS = 16;

    // Defaults for the top-level parameters
    localparam int DEFAULT_NUM_FLOORS  = 11;
    localparam int DEFAULT_QUEUE_DEPTH = 16;

    //////////////////////////////////////////////////////////////////////
    // Encodings
    //////////////////////////////////////////////////////////////////////

    // Dispatcher states
    typedef enum logic [1:0] {
        DISPATCH_IDLE   = 2'd0,
        DISPATCH_TRAVEL = 2'd1,
        DISPATCH_ARRIVE = 2'd2
    } dispatch_state_t;

    // Travel direction toward the car
    typedef enum logic {
        DIR_DOWN = 1'b0,
        DIR_UP   = 1'b1
    } direction_t;

endpackage

/* rtl/request_latch.sv */
// Accepts one press per cycle, panel before call and lowest floor first; held buttons re-press
`timescale 1ns/1ns

module request_latch #(
    parameter int NUM_FLOORS = elevator_pkg::DEFAULT_NUM_FLOORS
) (
    input  logic                             clock,
    input  logic                             reset_n,
    input  logic [NUM_FLOORS-1:0]            floor_call_buttons,
    input  logic [NUM_FLOORS-1:0]            panel_buttons,
    input  logic [elevator_pkg::FLOOR_W-1:0] current_floor,
    input  logic                             power_switch,
    input  logic                             emergency_btn,
    input  logic                             queue_full,
    input  logic                             arrive,
    output logic [NUM_FLOORS-1:0]            call_button_lights,
    output logic [NUM_FLOORS-1:0]            panel_button_lights,
    output logic                             push,
    output logic [elevator_pkg::FLOOR_W-1:0] push_floor
);

    import elevator_pkg::*;

    logic                  accept_ok;
    logic [NUM_FLOORS-1:0] at_floor;
    logic [NUM_FLOORS-1:0] pick_mask;
    logic [NUM_FLOORS-1:0] clear_mask;
    logic [NUM_FLOORS-1:0] panel_ok;
    logic [NUM_FLOORS-1:0] call_ok;
    logic                  pick_panel;

    // New requests only with power on, no emergency and room in the queue
    assign accept_ok = power_switch && !emergency_btn && !queue_full;

    // One-hot decodes of the car position and of the chosen floor
    always_comb begin
        for (int i = 0; i < NUM_FLOORS; i++) begin
            at_floor[i]  = (current_floor == FLOOR_W'(i));
            pick_mask[i] = push && (push_floor == FLOOR_W'(i));
        end
    end

    // A lit lamp or the current floor makes a button ineligible
    assign panel_ok = panel_buttons & ~panel_button_lights & ~at_floor & {NUM_FLOORS{accept_ok}};
    assign call_ok  = floor_call_buttons & ~call_button_lights & ~at_floor & {NUM_FLOORS{accept_ok}};

    assign clear_mask = arrive ? at_floor : '0;

    //////////////////////////////////////////////////////////////////////
    // Priority pick
    //////////////////////////////////////////////////////////////////////

    // Later loops override, so panel beats call and low floors win
    always_comb begin
        push       = 1'b0;
        push_floor = '0;
        pick_panel = 1'b0;
        for (int i = NUM_FLOORS - 1; i >= 0; i--) begin
            if (call_ok[i]) begin
                push       = 1'b1;
                push_floor = FLOOR_W'(i);
            end
        end
        for (int i = NUM_FLOORS - 1; i >= 0; i--) begin
            if (panel_ok[i]) begin
                push       = 1'b1;
                push_floor = FLOOR_W'(i);
                pick_panel = 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Lamps
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            call_button_lights  <= '0;
            panel_button_lights <= '0;
        end else if (!power_switch) begin
            // Power loss drops every pending request
            call_button_lights  <= '0;
            panel_button_lights <= '0;
        end else begin
            panel_button_lights <= (panel_button_lights & ~clear_mask)
                                 | (pick_panel ? pick_mask : '0);
            call_button_lights  <= (call_button_lights & ~clear_mask)
                                 | (pick_panel ? '0 : pick_mask);
        end
    end

    // The queue must never see a write it has no room for
    a_push_not_full: assert property (@(posedge clock) disable iff (!reset_n)
        push |-> !queue_full)
        else $error("request_latch: push while queue full");

    // Every queued floor maps to a real button
    a_push_floor_range: assert property (@(posedge clock) disable iff (!reset_n)
        push |-> (int'(push_floor) < NUM_FLOORS))
        else $error("request_latch: push_floor %0d out of range", push_floor);

endmodule

/* rtl/request_queue.sv */
// QUEUE_DEPTH must be at least 2; head_floor holds no meaning while queue_empty is high
`timescale 1ns/1ns

module request_queue #(
    parameter int QUEUE_DEPTH = elevator_pkg::DEFAULT_QUEUE_DEPTH
) (
    input  logic                             clock,
    input  logic                             reset_n,
    input  logic                             power_switch,
    input  logic                             push,
    input  logic [elevator_pkg::FLOOR_W-1:0] push_floor,
    input  logic                             pop,
    output logic [elevator_pkg::FLOOR_W-1:0] head_floor,
    output logic                             queue_empty,
    output logic                             queue_full
);

    import elevator_pkg::*;

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    logic [FLOOR_W-1:0] slots [QUEUE_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W-1:0]   rd_ptr_next;
    logic [CNT_W-1:0]   count;
    logic [CNT_W-1:0]   count_next;

    // Wrap for depths that are not a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign count_next  = count + CNT_W'(push) - CNT_W'(pop);
    assign rd_ptr_next = pop ? ptr_inc(rd_ptr) : rd_ptr;

    always_ff @(posedge clock) begin
        if (push) begin
            slots[wr_ptr] <= push_floor;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Pointers and flags
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            queue_empty <= 1'b1;
            queue_full  <= 1'b0;
        end else if (!power_switch) begin
            // Flush
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            queue_empty <= 1'b1;
            queue_full  <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            rd_ptr      <= rd_ptr_next;
            count       <= count_next;
            queue_empty <= (count_next == '0);
            queue_full  <= (count_next == CNT_W'(QUEUE_DEPTH));
        end
    end

    // Registered head: the pushed floor when the queue runs dry, else the next slot
    always_ff @(posedge clock) begin
        if (count == '0 || (pop && count == CNT_W'(1))) begin
            head_floor <= push_floor;
        end else if (pop) begin
            head_floor <= slots[rd_ptr_next];
        end
    end

    a_pop_not_empty: assert property (@(posedge clock) disable iff (!reset_n)
        pop |-> !queue_empty)
        else $error("request_queue: pop while empty");

    a_push_not_full: assert property (@(posedge clock) disable iff (!reset_n)
        push |-> !queue_full)
        else $error("request_queue: push while full");

endmodule

/* rtl/dispatcher.sv */
// One target at a time; direction is compared at the previous edge and lags a floor step by one cycle
`timescale 1ns/1ns

module dispatcher (
    input  logic                             clock,
    input  logic                             reset_n,
    input  logic                             power_switch,
    input  logic                             emergency_btn,
    input  logic [elevator_pkg::FLOOR_W-1:0] current_floor,
    input  logic                             elevator_moving,
    input  logic [elevator_pkg::FLOOR_W-1:0] head_floor,
    input  logic                             queue_empty,
    input  logic                             door_open_btn,
    input  logic                             door_close_btn,
    output logic                             pop,
    output logic                             arrive,
    output logic [elevator_pkg::FLOOR_W-1:0] elevator_floor_selector,
    output elevator_pkg::direction_t         direction_selector,
    output logic                             activate_elevator,
    output logic                             door_open_allowed,
    output logic                             door_close_allowed
);

    import elevator_pkg::*;

    dispatch_state_t state;
    dispatch_state_t state_next;
    logic            start;
    logic            at_target;
    logic            door_ok;

    // Take the oldest request once the car is idle and standing
    assign start = (state == DISPATCH_IDLE) && !queue_empty && power_switch
                && !emergency_btn && !elevator_moving;

    assign at_target = (current_floor == elevator_floor_selector) && !elevator_moving;

    assign pop    = start;
    assign arrive = (state == DISPATCH_ARRIVE);

    //////////////////////////////////////////////////////////////////////
    // State machine
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        state_next = state;
        if (!power_switch) begin
            state_next = DISPATCH_IDLE;
        end else begin
            case (state)
                DISPATCH_IDLE: begin
                    if (start) begin
                        state_next = DISPATCH_TRAVEL;
                    end
                end
                DISPATCH_TRAVEL: begin
                    if (at_target) begin
                        state_next = DISPATCH_ARRIVE;
                    end
                end
                DISPATCH_ARRIVE: state_next = DISPATCH_IDLE;
                default:         state_next = DISPATCH_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state                   <= DISPATCH_IDLE;
            elevator_floor_selector <= '0;
            direction_selector      <= DIR_DOWN;
            activate_elevator       <= 1'b0;
        end else begin
            state <= state_next;
            if (start) begin
                elevator_floor_selector <= head_floor;
                direction_selector      <= (head_floor > current_floor) ? DIR_UP : DIR_DOWN;
            end else if (state == DISPATCH_TRAVEL) begin
                direction_selector <= (elevator_floor_selector > current_floor) ? DIR_UP
                                                                                 : DIR_DOWN;
            end
            // Emergency holds the car but keeps the target
            activate_elevator <= (state_next == DISPATCH_TRAVEL) && !emergency_btn;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Door permits
    //////////////////////////////////////////////////////////////////////

    // Not while a dispatch is being issued this cycle
    assign door_ok = power_switch && !elevator_moving && !start
                  && (state == DISPATCH_IDLE || state == DISPATCH_ARRIVE);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            door_open_allowed  <= 1'b0;
            door_close_allowed <= 1'b0;
        end else begin
            door_open_allowed  <= door_ok && door_open_btn;
            // Open wins over close
            door_close_allowed <= door_ok && door_close_btn && !door_open_btn;
        end
    end

    // Doors stay shut whenever the car is driven
    a_door_exclusive: assert property (@(posedge clock) disable iff (!reset_n)
        !(door_open_allowed && door_close_allowed)
        && !(activate_elevator && (door_open_allowed || door_close_allowed)))
        else $error("dispatcher: door permit conflict");

    a_no_drive_unpowered: assert property (@(posedge clock) disable iff (!reset_n)
        !power_switch |=> !activate_elevator)
        else $error("dispatcher: car activated without power");

endmodule

/* rtl/floor_controller.sv */
// NUM_FLOORS may not exceed MAX_FLOORS; the car must report moving until it stands at a floor
`timescale 1ns/1ns

module floor_controller #(
    parameter int NUM_FLOORS  = elevator_pkg::DEFAULT_NUM_FLOORS,
    parameter int QUEUE_DEPTH = elevator_pkg::DEFAULT_QUEUE_DEPTH
) (
    input  logic                             clock,
    input  logic                             reset_n,
    input  logic [NUM_FLOORS-1:0]            floor_call_buttons,
    input  logic [NUM_FLOORS-1:0]            panel_buttons,
    input  logic                             door_open_btn,
    input  logic                             door_close_btn,
    input  logic                             emergency_btn,
    input  logic                             power_switch,
    input  logic [elevator_pkg::FLOOR_W-1:0] current_floor,
    input  logic                             elevator_moving,
    output logic [NUM_FLOORS-1:0]            call_button_lights,
    output logic [NUM_FLOORS-1:0]            panel_button_lights,
    output logic [elevator_pkg::FLOOR_W-1:0] elevator_floor_selector,
    output elevator_pkg::direction_t         direction_selector,
    output logic                             activate_elevator,
    output logic                             door_open_allowed,
    output logic                             door_close_allowed
);

    import elevator_pkg::*;

    // Latch to queue
    logic               push;
    logic [FLOOR_W-1:0] push_floor;
    logic               queue_full;

    // Queue to dispatcher and back
    logic [FLOOR_W-1:0] head_floor;
    logic               queue_empty;
    logic               pop;
    logic               arrive;

    request_latch #(
        .NUM_FLOORS(NUM_FLOORS)
    ) latch_i (
        .clock               (clock),
        .reset_n             (reset_n),
        .floor_call_buttons  (floor_call_buttons),
        .panel_buttons       (panel_buttons),
        .current_floor       (current_floor),
        .power_switch        (power_switch),
        .emergency_btn       (emergency_btn),
        .queue_full          (queue_full),
        .arrive              (arrive),
        .call_button_lights  (call_button_lights),
        .panel_button_lights (panel_button_lights),
        .push                (push),
        .push_floor          (push_floor)
    );

    request_queue #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) queue_i (
        .clock        (clock),
        .reset_n      (reset_n),
        .power_switch (power_switch),
        .push         (push),
        .push_floor   (push_floor),
        .pop          (pop),
        .head_floor   (head_floor),
        .queue_empty  (queue_empty),
        .queue_full   (queue_full)
    );

    dispatcher dispatch_i (
        .clock                   (clock),
        .reset_n                 (reset_n),
        .power_switch            (power_switch),
        .emergency_btn           (emergency_btn),
        .current_floor           (current_floor),
        .elevator_moving         (elevator_moving),
        .head_floor              (head_floor),
        .queue_empty             (queue_empty),
        .door_open_btn           (door_open_btn),
        .door_close_btn          (door_close_btn),
        .pop                     (pop),
        .arrive                  (arrive),
        .elevator_floor_selector (elevator_floor_selector),
        .direction_selector      (direction_selector),
        .activate_elevator       (activate_elevator),
        .door_open_allowed       (door_open_allowed),
        .door_close_allowed      (door_close_allowed)
    );

    a_floor_count: assert property (@(posedge clock) NUM_FLOORS <= MAX_FLOORS)
        else $error("floor_controller: NUM_FLOORS %0d above %0d", NUM_FLOORS, MAX_FLOORS);

endmodule

/* verif/car_model.sv */
// Behavioral car that starts at floor 0 and needs STEP_CYCLES clocks per floor; it halts when activate drops
`timescale 1ns/1ns

module car_model #(
    parameter int STEP_CYCLES = 8
) (
    input  logic                             clock,
    input  logic                             reset_n,
    input  logic                             activate_elevator,
    input  logic [elevator_pkg::FLOOR_W-1:0] elevator_floor_selector,
    output logic [elevator_pkg::FLOOR_W-1:0] current_floor,
    output logic                             elevator_moving
);

    import elevator_pkg::*;

    int                 step_count;
    logic [FLOOR_W-1:0] next_floor;

    // One floor toward the selector
    assign next_floor = (elevator_floor_selector > current_floor) ? current_floor + 1'b1
                                                                   : current_floor - 1'b1;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            current_floor   <= '0;
            elevator_moving <= 1'b0;
            step_count      <= 0;
        end else if (activate_elevator && current_floor != elevator_floor_selector) begin
            elevator_moving <= 1'b1;
            if (step_count == STEP_CYCLES - 1) begin
                step_count    <= 0;
                current_floor <= next_floor;
                // Stops as it lands on the target
                if (next_floor == elevator_floor_selector) begin
                    elevator_moving <= 1'b0;
                end
            end else begin
                step_count <= step_count + 1;
            end
        end else begin
            elevator_moving <= 1'b0;
            step_count      <= 0;
        end
    end

endmodule

/* verif/tb_floor_controller.sv */
// Runs the controller with the default 11 floors against car_model and stops at the first error
`timescale 1ns/1ns

module tb_floor_controller;

    import elevator_pkg::*;

    localparam int NUM_FLOORS  = DEFAULT_NUM_FLOORS;
    localparam int DRIVE_DELAY = 10;
    localparam int WAIT_LIMIT  = 3000;

    logic                  clock;
    logic                  reset_n;
    logic [NUM_FLOORS-1:0] floor_call_buttons;
    logic [NUM_FLOORS-1:0] panel_buttons;
    logic                  door_open_btn;
    logic                  door_close_btn;
    logic                  emergency_btn;
    logic                  power_switch;
    logic [FLOOR_W-1:0]    current_floor;
    logic                  elevator_moving;
    logic [NUM_FLOORS-1:0] call_button_lights;
    logic [NUM_FLOORS-1:0] panel_button_lights;
    logic [FLOOR_W-1:0]    elevator_floor_selector;
    direction_t            direction_selector;
    logic                  activate_elevator;
    logic                  door_open_allowed;
    logic                  door_close_allowed;

    integer seed = 32'h5bf7;
    int     expected_q[$];
    bit     in_service;
    bit     activate_prev;
    int     clear_wait;
    int     clear_floor;

    floor_controller #(
        .NUM_FLOORS(NUM_FLOORS)
    ) dut_i (
        .clock                   (clock),
        .reset_n                 (reset_n),
        .floor_call_buttons      (floor_call_buttons),
        .panel_buttons           (panel_buttons),
        .door_open_btn           (door_open_btn),
        .door_close_btn          (door_close_btn),
        .emergency_btn           (emergency_btn),
        .power_switch            (power_switch),
        .current_floor           (current_floor),
        .elevator_moving         (elevator_moving),
        .call_button_lights      (call_button_lights),
        .panel_button_lights     (panel_button_lights),
        .elevator_floor_selector (elevator_floor_selector),
        .direction_selector      (direction_selector),
        .activate_elevator       (activate_elevator),
        .door_open_allowed       (door_open_allowed),
        .door_close_allowed      (door_close_allowed)
    );

    car_model car_i (
        .clock                   (clock),
        .reset_n                 (reset_n),
        .activate_elevator       (activate_elevator),
        .elevator_floor_selector (elevator_floor_selector),
        .current_floor           (current_floor),
        .elevator_moving         (elevator_moving)
    );

    initial clock = 1'b0;
    always #50 clock = ~clock;

    //////////////////////////////////////////////////////////////////////
    // Reporting and helpers
    //////////////////////////////////////////////////////////////////////

    task automatic report_mismatch(input string test, input int expected, input int actual);
        $display("MISMATCH %s expected %0d actual %0d", test, expected, actual);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic report_error(input string what);
        $display("ERROR %s", what);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_value(input string test, input int expected, input int actual);
        if (expected != actual) begin
            report_mismatch(test, expected, actual);
        end
    endtask

    task automatic next_cycle();
        @(posedge clock);
        #DRIVE_DELAY;
    endtask

    // Random floor away from the car with both lamps dark
    function automatic int pick_floor();
        int f;
        for (int tries = 0; tries < 64; tries++) begin
            f = $unsigned($random(seed)) % NUM_FLOORS;
            if (f != current_floor && !panel_button_lights[f] && !call_button_lights[f]) begin
                return f;
            end
        end
        return (current_floor == 0) ? 1 : 0;
    endfunction

    // One-cycle press; the lamp prediction follows the eligibility rule
    task automatic press_button(input bit use_panel, input int f, input string test);
        bit lit_before;
        bit eligible;
        lit_before = use_panel ? panel_button_lights[f] : call_button_lights[f];
        eligible   = !lit_before && (current_floor != f) && power_switch && !emergency_btn;
        if (use_panel) panel_buttons[f] = 1'b1;
        else floor_call_buttons[f] = 1'b1;
        next_cycle();
        panel_buttons      = '0;
        floor_call_buttons = '0;
        check_value(test, int'(eligible || lit_before),
                    int'(use_panel ? panel_button_lights[f] : call_button_lights[f]));
        if (eligible) begin
            expected_q.push_back(f);
        end
    endtask

    task automatic wait_for_activate();
        int cycles;
        cycles = 0;
        while (!activate_elevator) begin
            if (cycles == WAIT_LIMIT) report_error("activate_elevator never rose");
            next_cycle();
            cycles++;
        end
    endtask

    // All accepted requests served and the car standing
    task automatic wait_idle();
        int cycles;
        cycles = 0;
        while (expected_q.size() != 0 || in_service || activate_elevator || clear_wait != 0) begin
            if (cycles == WAIT_LIMIT) report_error("pending requests were never served");
            next_cycle();
            cycles++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Dispatch monitor
    //////////////////////////////////////////////////////////////////////

    always @(posedge clock) begin
        if (!reset_n || !power_switch) begin
            expected_q.delete();
            in_service = 1'b0;
            clear_wait = 0;
        end else begin
            if (activate_elevator && !activate_prev) begin
                if (in_service) begin
                    // Resume after an emergency keeps the target
                    check_value("resume", clear_floor, elevator_floor_selector);
                end else if (expected_q.size() == 0) begin
                    report_error("activation without a pending request");
                end else begin
                    check_value("fifo_order", expected_q.pop_front(), elevator_floor_selector);
                    clear_floor = elevator_floor_selector;
                    in_service  = 1'b1;
                end
            end
            if (clear_wait != 0) begin
                clear_wait--;
                if (clear_wait == 0) begin
                    check_value("lamp_clear", 0, panel_button_lights[clear_floor]
                                              | call_button_lights[clear_floor]);
                end
            end
            // Car standing at the target, lamps due two cycles later
            if (in_service && !elevator_moving && current_floor == elevator_floor_selector) begin
                in_service = 1'b0;
                clear_wait = 2;
            end
        end
        activate_prev = activate_elevator;
    end

    //////////////////////////////////////////////////////////////////////
    // Assertions
    //////////////////////////////////////////////////////////////////////

    a_direction: assert property (@(posedge clock) disable iff (!reset_n)
        activate_elevator && elevator_floor_selector != current_floor
        |-> direction_selector == ((elevator_floor_selector > current_floor) ? DIR_UP : DIR_DOWN))
        else report_mismatch("direction", int'(elevator_floor_selector > current_floor),
                             int'(direction_selector));

    a_emergency: assert property (@(posedge clock) disable iff (!reset_n)
        $past(emergency_btn) |-> !activate_elevator
        && ((panel_button_lights & ~$past(panel_button_lights)) == '0)
        && ((call_button_lights & ~$past(call_button_lights)) == '0))
        else report_error("lamp or activate rose during emergency");

    a_power_off: assert property (@(posedge clock) disable iff (!reset_n)
        $past(!power_switch) && !power_switch
        |-> !activate_elevator && panel_button_lights == '0 && call_button_lights == '0)
        else report_error("lamps or activate still high after power off");

    a_door_exclusive: assert property (@(posedge clock) disable iff (!reset_n)
        !(door_open_allowed && door_close_allowed)
        && !(activate_elevator && (door_open_allowed || door_close_allowed)))
        else report_error("door permits overlap or granted while activated");

    a_door_follow: assert property (@(posedge clock) disable iff (!reset_n)
        (door_open_allowed || door_close_allowed)
        |-> $past(door_open_btn || door_close_btn) && !$past(elevator_moving)
        && !$past(activate_elevator) && $past(power_switch))
        else report_error("door permit without button or while car busy");

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        reset_n            = 1'b0;
        floor_call_buttons = '0;
        panel_buttons      = '0;
        door_open_btn      = 1'b0;
        door_close_btn     = 1'b0;
        emergency_btn      = 1'b0;
        power_switch       = 1'b1;
        repeat (2) @(posedge clock);
        #DRIVE_DELAY;
        reset_n = 1'b1;
        next_cycle();

        // Door permits with the car idle
        door_open_btn = 1'b1;
        next_cycle();
        check_value("door_open", 1, door_open_allowed);
        door_close_btn = 1'b1;
        next_cycle();
        check_value("door_open_wins", 0, door_close_allowed);
        door_open_btn = 1'b0;
        next_cycle();
        check_value("door_close", 1, door_close_allowed);
        door_close_btn = 1'b0;
        next_cycle();
        check_value("door_release", 0, door_open_allowed | door_close_allowed);

        // Own floor never lights
        press_button(1'b1, current_floor, "own_floor_panel");
        press_button(1'b0, current_floor, "own_floor_call");

        // Burst of requests served in order
        for (int i = 0; i < 4; i++) begin
            press_button(i[0], pick_floor(), "fifo_press");
        end

        // Door open is refused while the car travels
        wait_for_activate();
        door_open_btn = 1'b1;
        repeat (3) next_cycle();
        check_value("door_busy", 0, door_open_allowed);
        door_open_btn = 1'b0;
        wait_idle();

        // Emergency in the middle of a trip
        for (int i = 0; i < 3; i++) begin
            press_button(i[0], pick_floor(), "emergency_press");
        end
        wait_for_activate();
        repeat (3) next_cycle();
        emergency_btn  = 1'b1;
        door_close_btn = 1'b1;
        press_button(1'b1, pick_floor(), "emergency_blocked");
        repeat (10) next_cycle();
        check_value("door_halted", 0, door_close_allowed);
        door_close_btn = 1'b0;
        emergency_btn  = 1'b0;
        wait_idle();

        // Power loss flushes everything
        for (int i = 0; i < 3; i++) begin
            press_button(i[0], pick_floor(), "power_press");
        end
        wait_for_activate();
        power_switch = 1'b0;
        repeat (3) next_cycle();
        check_value("power_lamps", 0, int'(|{panel_button_lights, call_button_lights}));
        power_switch = 1'b1;
        for (int i = 0; i < 40; i++) begin
            next_cycle();
            check_value("power_restart", 0, activate_elevator);
        end

        $display("Simulation passed");
        $finish;
    end

endmodule

/* files.f */
rtl/elevator_pkg.sv
rtl/request_latch.sv
rtl/request_queue.sv
rtl/dispatcher.sv
rtl/floor_controller.sv
verif/car_model.sv
verif/tb_floor_controller.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_floor_controller
FILELIST = files.f

BUILD    = obj_dir
BIN      = $(BUILD)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^Simulation passed$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
